/* rtl/ex_pkg.sv */
/*
 execute unit common definitions
 word width, operation encoding and divider defaults
*/

package ex_pkg;

	localparam int XLEN = 32;		// operand and result width
	localparam int DIV_BITS_DEFAULT = 1;	// quotient bits retired per divide step

	typedef logic [XLEN-1:0] xlen_t;

	typedef enum logic [4:0] {
		op_add,
		op_sub,
		op_slt,
		op_sltu,
		op_and,
		op_or,
		op_xor,
		op_sll,
		op_srl,
		op_sra,
		op_beq,			// branch compares
		op_bne,
		op_blt,
		op_bge,
		op_bltu,
		op_bgeu,
		op_mul,			// multiplies
		op_mulh,
		op_mulhsu,
		op_mulhu,
		op_div,			// iterative divides
		op_divu,
		op_rem,
		op_remu
	} ex_op_e;

	function automatic logic is_div_op(ex_op_e op);
		return op inside {op_div, op_divu, op_rem, op_remu};
	endfunction

	function automatic logic is_mul_op(ex_op_e op);
		return op inside {op_mul, op_mulh, op_mulhsu, op_mulhu};
	endfunction

	// compares that only produce the taken flag
	function automatic logic is_branch_op(ex_op_e op);
		return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
	endfunction

endpackage

/* rtl/ex_bus_pkg.sv */
/*
 execute unit handshake payloads
 request and response words moved across valid/ready
*/

package ex_bus_pkg;

	// request from the decode side
	typedef struct packed {
		ex_pkg::ex_op_e	op;		// operation to run
		ex_pkg::xlen_t	src1;		// first operand, dividend
		ex_pkg::xlen_t	src2;		// second operand, divisor or shift amount
	} ex_req_t;

	// response toward the next stage
	typedef struct packed {
		ex_pkg::xlen_t	result;		// zero for branch compares
		logic		taken;		// branch taken flag
	} ex_rsp_t;

endpackage

/* rtl/ex_ctrl.sv */
/*
 execute unit control
 runs the valid/ready handshake, sequences divides and
 registers the selected response
*/

`timescale 1ns/1ps

module ex_ctrl (
	input  logic			cpu_clk,
	input  logic			reset,
	input  logic			in_valid,
	output logic			in_ready,
	input  ex_bus_pkg::ex_req_t	in_req,
	output logic			out_valid,
	input  logic			out_ready,
	output ex_bus_pkg::ex_rsp_t	out_rsp,
	output ex_bus_pkg::ex_req_t	held_req,
	input  ex_bus_pkg::ex_rsp_t	alu_rsp,
	input  ex_bus_pkg::ex_rsp_t	md_rsp,
	output logic			div_start,
	output logic			div_step,
	input  logic			last_step
);

	typedef enum logic [1:0] {st_idle, st_div, st_done} state_e;

	state_e			state;
	logic			accept;
	logic			capture;
	ex_bus_pkg::ex_rsp_t	sel_rsp;

	assign in_ready = (state == st_idle);	// one item in flight
	assign accept = in_valid && in_ready;
	assign capture = (state == st_done) && !out_valid;	// result settles here

	// multiplies and divides come from the datapath
	assign sel_rsp = (ex_pkg::is_mul_op(held_req.op) || ex_pkg::is_div_op(held_req.op)) ?
			 md_rsp : alu_rsp;

	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			state <= st_idle;
			div_start <= 1'b0;
			div_step <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			div_start <= 1'b0;	// single cycle pulse
			case (state)
			st_idle: begin
				if (accept) begin
					if (ex_pkg::is_div_op(in_req.op)) begin
						div_start <= 1'b1;
						state <= st_div;
					end else begin
						state <= st_done;
					end
				end
			end
			st_div: begin
				if (div_start)
					div_step <= 1'b1;	// operands loaded, start iterating
				else if (last_step) begin
					div_step <= 1'b0;
					state <= st_done;
				end
			end
			st_done: begin
				if (!out_valid)
					out_valid <= 1'b1;
				else if (out_ready) begin
					out_valid <= 1'b0;
					state <= st_idle;
				end
			end
			default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (accept)
			held_req <= in_req;
		if (capture)
			out_rsp <= sel_rsp;	// held until the response transfers
	end

	a_rsp_stable: assert property (@(posedge cpu_clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_rsp))
		else $error("response changed under back-pressure");

	a_no_overlap: assert property (@(posedge cpu_clk) disable iff (reset)
		!(in_ready && out_valid))
		else $error("request accepted while a response is pending");

	a_step_in_div: assert property (@(posedge cpu_clk) disable iff (reset)
		div_step |-> state == st_div)
		else $error("divide step outside of a division");

endmodule

/* rtl/div_step_counter.sv */
/*
 divider iteration counter
 counts down the remaining steps and flags the last one
*/

`timescale 1ns/1ps

module div_step_counter #(
	parameter int DIV_BITS = ex_pkg::DIV_BITS_DEFAULT
) (
	input  logic	cpu_clk,
	input  logic	reset,
	input  logic	div_start,
	input  logic	div_step,
	output logic	last_step
);

	localparam int STEPS = ex_pkg::XLEN / DIV_BITS;
	localparam int CNT_W = $clog2(STEPS + 1);

	logic [CNT_W-1:0] count;	// steps still to run

	always_ff @(posedge cpu_clk) begin
		if (reset)
			count <= '0;
		else if (div_start)
			count <= CNT_W'(STEPS);
		else if (div_step)
			count <= count - 1'b1;
	end

	assign last_step = div_step && (count == CNT_W'(1));

	a_no_underflow: assert property (@(posedge cpu_clk) disable iff (reset)
		div_step |-> count != '0)
		else $error("divide step with no steps left");

endmodule

/* rtl/int_alu.sv */
/*
 integer ALU
 single cycle arithmetic, logic, shifts and branch compares
*/

`timescale 1ns/1ps

module int_alu (
	input  ex_bus_pkg::ex_req_t	held_req,
	output ex_bus_pkg::ex_rsp_t	alu_rsp
);

	ex_pkg::xlen_t	src1;
	ex_pkg::xlen_t	src2;
	logic [4:0]	shamt;
	logic		eq;
	logic		lt_s;
	logic		lt_u;
	logic		cmp;

	assign src1 = held_req.src1;
	assign src2 = held_req.src2;
	assign shamt = src2[4:0];	// upper bits ignored

	assign eq = (src1 == src2);
	assign lt_s = ($signed(src1) < $signed(src2));
	assign lt_u = (src1 < src2);

	always_comb begin
		case (held_req.op)
		ex_pkg::op_beq:		cmp = eq;
		ex_pkg::op_bne:		cmp = !eq;
		ex_pkg::op_blt:		cmp = lt_s;
		ex_pkg::op_bge:		cmp = !lt_s;
		ex_pkg::op_bltu:	cmp = lt_u;
		ex_pkg::op_bgeu:	cmp = !lt_u;
		default:		cmp = 1'b0;
		endcase
	end

	always_comb begin
		alu_rsp.taken = ex_pkg::is_branch_op(held_req.op) && cmp;
		case (held_req.op)
		ex_pkg::op_add:		alu_rsp.result = src1 + src2;
		ex_pkg::op_sub:		alu_rsp.result = src1 - src2;
		ex_pkg::op_slt:		alu_rsp.result = ex_pkg::xlen_t'(lt_s);
		ex_pkg::op_sltu:	alu_rsp.result = ex_pkg::xlen_t'(lt_u);
		ex_pkg::op_and:		alu_rsp.result = src1 & src2;
		ex_pkg::op_or:		alu_rsp.result = src1 | src2;
		ex_pkg::op_xor:		alu_rsp.result = src1 ^ src2;
		ex_pkg::op_sll:		alu_rsp.result = src1 << shamt;
		ex_pkg::op_srl:		alu_rsp.result = src1 >> shamt;
		ex_pkg::op_sra:		alu_rsp.result = $signed(src1) >>> shamt;
		default:		alu_rsp.result = '0;	// branches and non-alu ops
		endcase
	end

endmodule

/* rtl/mul_div_dp.sv */
/*
 multiply and divide datapath
 combinational multiplier and an iterative restoring divider
 working on magnitudes with sign and corner-case fix-up
*/

`timescale 1ns/1ps

module mul_div_dp #(
	parameter int DIV_BITS = ex_pkg::DIV_BITS_DEFAULT
) (
	input  logic			cpu_clk,
	input  logic			reset,
	input  ex_bus_pkg::ex_req_t	held_req,
	input  logic			div_start,
	input  logic			div_step,
	output ex_bus_pkg::ex_rsp_t	md_rsp
);

	localparam int XLEN = ex_pkg::XLEN;

	ex_pkg::ex_op_e			op;
	logic				a_signed;
	logic				b_signed;
	logic signed [XLEN:0]		mul_a;
	logic signed [XLEN:0]		mul_b;
	logic signed [2*XLEN-1:0]	product;

	logic				div_signed;
	logic				src1_neg;
	logic				src2_neg;
	ex_pkg::xlen_t			src1_mag;
	ex_pkg::xlen_t			src2_mag;
	ex_pkg::xlen_t			quo_q;
	ex_pkg::xlen_t			rem_q;
	ex_pkg::xlen_t			dvsr_q;
	logic [XLEN:0]			rem_nxt;
	ex_pkg::xlen_t			quo_nxt;
	logic				neg_q;
	logic				neg_r;
	logic				dvsr_zero;
	logic				div_ovf;
	ex_pkg::xlen_t			quo_fix;
	ex_pkg::xlen_t			rem_fix;

	assign op = held_req.op;

	// one extra bit so signed and unsigned share one multiplier
	assign a_signed = (op == ex_pkg::op_mulh) || (op == ex_pkg::op_mulhsu);
	assign b_signed = (op == ex_pkg::op_mulh);
	assign mul_a = {a_signed & held_req.src1[XLEN-1], held_req.src1};
	assign mul_b = {b_signed & held_req.src2[XLEN-1], held_req.src2};
	assign product = mul_a * mul_b;

	assign div_signed = (op == ex_pkg::op_div) || (op == ex_pkg::op_rem);
	assign src1_neg = div_signed && held_req.src1[XLEN-1];
	assign src2_neg = div_signed && held_req.src2[XLEN-1];
	assign src1_mag = src1_neg ? -held_req.src1 : held_req.src1;
	assign src2_mag = src2_neg ? -held_req.src2 : held_req.src2;

	// restoring steps, dividend shifts out of quo as quotient bits shift in
	always_comb begin
		rem_nxt = {1'b0, rem_q};
		quo_nxt = quo_q;
		for (int i = 0; i < DIV_BITS; i++) begin
			rem_nxt = {rem_nxt[XLEN-1:0], quo_nxt[XLEN-1]};
			quo_nxt = {quo_nxt[XLEN-2:0], 1'b0};
			if (rem_nxt >= {1'b0, dvsr_q}) begin
				rem_nxt = rem_nxt - {1'b0, dvsr_q};
				quo_nxt[0] = 1'b1;
			end
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (div_start) begin
			quo_q <= src1_mag;
			rem_q <= '0;
			dvsr_q <= src2_mag;
		end else if (div_step) begin
			quo_q <= quo_nxt;
			rem_q <= rem_nxt[XLEN-1:0];	// always below the divisor
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			neg_q <= 1'b0;
			neg_r <= 1'b0;
			dvsr_zero <= 1'b0;
			div_ovf <= 1'b0;
		end else if (div_start && ex_pkg::is_div_op(op)) begin
			neg_q <= src1_neg ^ src2_neg;
			neg_r <= src1_neg;	// remainder follows the dividend
			dvsr_zero <= (held_req.src2 == '0);
			div_ovf <= div_signed && (held_req.src1 == {1'b1, {(XLEN-1){1'b0}}}) &&
				   (held_req.src2 == '1);
		end
	end

	assign quo_fix = dvsr_zero ? '1 :
			 div_ovf ? held_req.src1 :
			 neg_q ? -quo_q : quo_q;
	assign rem_fix = dvsr_zero ? held_req.src1 :
			 div_ovf ? '0 :
			 neg_r ? -rem_q : rem_q;

	always_comb begin
		md_rsp.taken = 1'b0;
		case (op)
		ex_pkg::op_mul:		md_rsp.result = product[XLEN-1:0];
		ex_pkg::op_mulh,
		ex_pkg::op_mulhsu,
		ex_pkg::op_mulhu:	md_rsp.result = product[2*XLEN-1:XLEN];
		ex_pkg::op_div,
		ex_pkg::op_divu:	md_rsp.result = quo_fix;
		ex_pkg::op_rem,
		ex_pkg::op_remu:	md_rsp.result = rem_fix;
		default:		md_rsp.result = '0;
		endcase
	end

endmodule

/* rtl/ex_unit.sv */
/*
 execute unit top
 ALU, multiplier and iterative divider behind one
 valid/ready request and response pair
*/

`timescale 1ns/1ps

module ex_unit #(
	parameter int DIV_BITS = ex_pkg::DIV_BITS_DEFAULT	// quotient bits per cycle
) (
	input  logic			cpu_clk,
	input  logic			reset,
	input  logic			in_valid,
	output logic			in_ready,
	input  ex_bus_pkg::ex_req_t	in_req,
	output logic			out_valid,
	input  logic			out_ready,
	output ex_bus_pkg::ex_rsp_t	out_rsp
);

	ex_bus_pkg::ex_req_t	held_req;	// operation under execution
	ex_bus_pkg::ex_rsp_t	alu_rsp;
	ex_bus_pkg::ex_rsp_t	md_rsp;
	logic			div_start;
	logic			div_step;
	logic			last_step;

	ex_ctrl u_ctrl (
		.cpu_clk	(cpu_clk),
		.reset		(reset),
		.in_valid	(in_valid),
		.in_ready	(in_ready),
		.in_req		(in_req),
		.out_valid	(out_valid),
		.out_ready	(out_ready),
		.out_rsp	(out_rsp),
		.held_req	(held_req),
		.alu_rsp	(alu_rsp),
		.md_rsp		(md_rsp),
		.div_start	(div_start),
		.div_step	(div_step),
		.last_step	(last_step)
	);

	div_step_counter #(.DIV_BITS(DIV_BITS)) u_div_cnt (
		.cpu_clk	(cpu_clk),
		.reset		(reset),
		.div_start	(div_start),
		.div_step	(div_step),
		.last_step	(last_step)
	);

	int_alu u_alu (
		.held_req	(held_req),
		.alu_rsp	(alu_rsp)
	);

	mul_div_dp #(.DIV_BITS(DIV_BITS)) u_mul_div (
		.cpu_clk	(cpu_clk),
		.reset		(reset),
		.held_req	(held_req),
		.div_start	(div_start),
		.div_step	(div_step),
		.md_rsp		(md_rsp)
	);

endmodule

/* testbench/tb_ex_ref.svh */
/*
 execute unit testbench helpers
 Galois LFSR step and the reference model of every operation
*/

`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

// right shifting Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(logic [31:0] state);
	logic [31:0] nxt;
	nxt = state >> 1;
	if (state[0])
		nxt = nxt ^ 32'h8020_0003;
	return nxt;
endfunction

function automatic ex_bus_pkg::ex_rsp_t ex_ref(ex_bus_pkg::ex_req_t req);
	ex_bus_pkg::ex_rsp_t	rsp;
	ex_pkg::xlen_t		a;
	ex_pkg::xlen_t		b;
	int			sa;
	int			sb;
	int			quo;
	int			rmd;
	logic [63:0]		p;
	logic			div_zero;
	logic			ovf;
	a = req.src1;
	b = req.src2;
	sa = a;
	sb = b;
	div_zero = (b == '0);
	ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);	// most negative over minus one
	rsp.result = '0;
	rsp.taken = 1'b0;
	case (req.op)
	ex_pkg::op_add:		rsp.result = a + b;
	ex_pkg::op_sub:		rsp.result = a - b;
	ex_pkg::op_slt:		rsp.result = (sa < sb) ? 32'd1 : 32'd0;
	ex_pkg::op_sltu:	rsp.result = (a < b) ? 32'd1 : 32'd0;
	ex_pkg::op_and:		rsp.result = a & b;
	ex_pkg::op_or:		rsp.result = a | b;
	ex_pkg::op_xor:		rsp.result = a ^ b;
	ex_pkg::op_sll:		rsp.result = a << b[4:0];
	ex_pkg::op_srl:		rsp.result = a >> b[4:0];
	ex_pkg::op_sra:		rsp.result = sa >>> b[4:0];
	ex_pkg::op_beq:		rsp.taken = (a == b);
	ex_pkg::op_bne:		rsp.taken = (a != b);
	ex_pkg::op_blt:		rsp.taken = (sa < sb);
	ex_pkg::op_bge:		rsp.taken = (sa >= sb);
	ex_pkg::op_bltu:	rsp.taken = (a < b);
	ex_pkg::op_bgeu:	rsp.taken = (a >= b);
	ex_pkg::op_mul: begin
		p = {32'b0, a} * {32'b0, b};
		rsp.result = p[31:0];
	end
	ex_pkg::op_mulh: begin
		p = {{32{a[31]}}, a} * {{32{b[31]}}, b};	// low 64 bits are exact
		rsp.result = p[63:32];
	end
	ex_pkg::op_mulhsu: begin
		p = {{32{a[31]}}, a} * {32'b0, b};
		rsp.result = p[63:32];
	end
	ex_pkg::op_mulhu: begin
		p = {32'b0, a} * {32'b0, b};
		rsp.result = p[63:32];
	end
	ex_pkg::op_div: begin
		if (div_zero)
			rsp.result = '1;
		else if (ovf)
			rsp.result = a;
		else begin
			quo = sa / sb;	// truncates toward zero
			rsp.result = quo;
		end
	end
	ex_pkg::op_divu:	rsp.result = div_zero ? '1 : a / b;
	ex_pkg::op_rem: begin
		if (div_zero)
			rsp.result = a;
		else if (ovf)
			rsp.result = '0;
		else begin
			rmd = sa % sb;	// sign of the dividend
			rsp.result = rmd;
		end
	end
	ex_pkg::op_remu:	rsp.result = div_zero ? a : a % b;
	default:		rsp.result = '0;
	endcase
	return rsp;
endfunction

`endif

/* testbench/tb_ex_unit.sv */
/*
 execute unit testbench
 random and corner requests checked against the reference model,
 with random back-pressure on the response side
*/

`timescale 1ns/1ps

module tb_ex_unit;

	localparam int N_ALU = 8;	// per alu op
	localparam int N_BR = 6;	// random pairs per branch op
	localparam int N_MD = 6;	// random pairs per mul/div op
	localparam int N_BP = 40;
	localparam int N_TESTS = 10 * N_ALU + 6 * (N_BR + 5) + 8 * (N_MD + 25) + N_BP;
	localparam longint WATCHDOG_NS = longint'(N_TESTS + 2) * (34 + 16) * 20;

	logic			cpu_clk;
	logic			reset;
	logic			in_valid;
	logic			in_ready;
	ex_bus_pkg::ex_req_t	in_req;
	logic			out_valid;
	logic			out_ready;
	ex_bus_pkg::ex_rsp_t	out_rsp;

	logic [31:0]		stim_lfsr = 32'hf748;
	logic [31:0]		rdy_lfsr = 32'hf748;
	logic			bp_mode = 1'b0;		// random out_ready when set
	ex_bus_pkg::ex_rsp_t	exp_q[$];
	string			name_q[$];
	int			sent = 0;
	int			received = 0;
	int			result_errs = 0;
	int			taken_errs = 0;
	int			proto_errs = 0;

	`include "tb_ex_ref.svh"

	ex_unit ex_unit_i (
		.cpu_clk	(cpu_clk),
		.reset		(reset),
		.in_valid	(in_valid),
		.in_ready	(in_ready),
		.in_req		(in_req),
		.out_valid	(out_valid),
		.out_ready	(out_ready),
		.out_rsp	(out_rsp)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #10 cpu_clk = ~cpu_clk;
	end

	function automatic ex_pkg::xlen_t stim_bits(int n);
		ex_pkg::xlen_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	function automatic ex_pkg::xlen_t corner(int i);
		case (i)
		0:	return 32'h0000_0000;
		1:	return 32'h0000_0001;
		2:	return 32'hffff_ffff;
		3:	return 32'h8000_0000;
		default: return 32'h7fff_ffff;
		endcase
	endfunction

	function automatic ex_bus_pkg::ex_req_t mk_req(ex_pkg::ex_op_e op, ex_pkg::xlen_t a,
						       ex_pkg::xlen_t b);
		ex_bus_pkg::ex_req_t r;
		r.op = op;
		r.src1 = a;
		r.src2 = b;
		return r;
	endfunction

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic send(ex_bus_pkg::ex_req_t req);
		in_req = req;
		in_valid = 1'b1;
		while (!in_ready)
			@(negedge cpu_clk);
		@(negedge cpu_clk);
		exp_q.push_back(ex_ref(req));
		name_q.push_back($sformatf("%s #%0d", req.op.name(), sent));
		sent++;
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (received != sent)
			@(negedge cpu_clk);
	endtask

	task automatic check_result(string name, ex_pkg::xlen_t exp, ex_pkg::xlen_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s result: expected %08h, actual %08h", name, exp, act);
			result_errs++;
		end
	endtask

	task automatic check_taken(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("CHECK FAILED %s taken: expected %b, actual %b", name, exp, act);
			taken_errs++;
		end
	endtask

	// response side, out_ready and both handshake signals settle before the falling edge
	initial begin
		ex_bus_pkg::ex_rsp_t	exp;
		ex_bus_pkg::ex_rsp_t	held_rsp;
		logic			held_valid;
		string			name;
		held_valid = 1'b0;
		wait (reset == 1'b0);
		forever begin
			@(negedge cpu_clk);
			if (bp_mode) begin
				rdy_lfsr = lfsr_step(rdy_lfsr);
				out_ready = rdy_lfsr[0];
			end else begin
				out_ready = 1'b1;
			end
			if (in_ready && out_valid) begin
				$display("ready for a new request while a response is still waiting");
				proto_errs++;
			end
			if (held_valid && !out_valid) begin
				$display("response withdrawn before it was taken");
				proto_errs++;
			end
			if (held_valid && out_valid) begin
				check_result("held response", held_rsp.result, out_rsp.result);
				check_taken("held response", held_rsp.taken, out_rsp.taken);
			end
			if (out_valid && out_ready) begin
				held_valid = 1'b0;
				received++;
				if (exp_q.size() == 0) begin
					$display("response delivered with no request outstanding");
					proto_errs++;
				end else begin
					exp = exp_q.pop_front();
					name = name_q.pop_front();
					check_result(name, exp.result, out_rsp.result);
					check_taken(name, exp.taken, out_rsp.taken);
				end
			end else if (out_valid) begin
				held_valid = 1'b1;	// stalled, must stay put
				held_rsp = out_rsp;
			end else begin
				held_valid = 1'b0;
			end
		end
	end

	initial begin
		ex_pkg::xlen_t	a;
		ex_pkg::xlen_t	b;
		ex_pkg::xlen_t	sh;
		ex_pkg::ex_op_e	op;
		int		errs;
		reset = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		out_ready = 1'b0;
		repeat (5) @(posedge cpu_clk);
		@(negedge cpu_clk);
		reset = 1'b0;
		if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
			$display("after reset in_ready is not high or out_valid is not low");
			proto_errs++;
		end

		// alu ops, full 32-bit src2 so shifts see amounts above 31
		for (int k = 0; k < 10; k++) begin
			for (int n = 0; n < N_ALU; n++) begin
				a = stim_bits(32);
				b = stim_bits(32);
				send(mk_req(ex_pkg::ex_op_e'(int'(ex_pkg::op_add) + k), a, b));
			end
		end

		// branch compares
		for (int k = 0; k < 6; k++) begin
			op = ex_pkg::ex_op_e'(int'(ex_pkg::op_beq) + k);
			for (int n = 0; n < N_BR; n++) begin
				a = stim_bits(32);
				b = stim_bits(32);
				send(mk_req(op, a, b));
			end
			a = stim_bits(32);
			send(mk_req(op, a, a));
			send(mk_req(op, 32'h7fff_ffff, 32'h8000_0000));
			send(mk_req(op, 32'h8000_0000, 32'h7fff_ffff));
			send(mk_req(op, 32'h0000_0000, 32'hffff_ffff));
			send(mk_req(op, 32'hffff_ffff, 32'h0000_0000));
		end

		// multiplies then divides, random and every corner pair
		for (int k = 0; k < 8; k++) begin
			op = ex_pkg::ex_op_e'(int'(ex_pkg::op_mul) + k);
			for (int n = 0; n < N_MD; n++) begin
				a = stim_bits(32);
				b = stim_bits(32);
				sh = stim_bits(5);
				if (ex_pkg::is_div_op(op))
					b = b >> sh;	// spread divisor sizes
				send(mk_req(op, a, b));
			end
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					send(mk_req(op, corner(i), corner(j)));
		end

		// random mix under back-pressure
		drain();
		@(posedge cpu_clk);
		bp_mode = 1'b1;
		@(negedge cpu_clk);
		for (int n = 0; n < N_BP; n++) begin
			op = ex_pkg::ex_op_e'(stim_bits(5) % (int'(ex_pkg::op_remu) + 1));
			a = stim_bits(32);
			b = stim_bits(32);
			send(mk_req(op, a, b));
		end
		drain();
		@(negedge cpu_clk);

		errs = result_errs + taken_errs + proto_errs;
		$display("errors: %0d result, %0d taken, %0d protocol, %0d of %0d responses seen",
			 result_errs, taken_errs, proto_errs, received, sent);
		if (errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, %0d of %0d responses seen", received, sent);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* src.f */
rtl/ex_pkg.sv
rtl/ex_bus_pkg.sv
rtl/ex_ctrl.sv
rtl/div_step_counter.sv
rtl/int_alu.sv
rtl/mul_div_dp.sv
rtl/ex_unit.sv
+incdir+testbench
testbench/tb_ex_unit.sv
